/* project.f */
verilog/cacheGeomPkg.sv
verilog/fetchBusPkg.sv
verilog/icacheArray.sv
verilog/refillEngine.sv
verilog/fetchControl.sv
verilog/icacheTop.sv
tests/clockGen.sv
tests/memModel.sv
tests/icacheTb.sv

/* run.sh */
#!/usr/bin/env bash
# build the instruction cache testbench with Verilator and run it
# exit status is the simulator's own, nonzero after a $fatal

cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
  --top-module icacheTb \
  -f project.f \
  --Mdir obj_dir -o icacheSim &&
./obj_dir/icacheSim ||
exit 1

/* tests/icacheTb.sv */
// instruction cache testbench driving cold misses, hits, conflicts, flush and a random fetch run
module icacheTb
  import cacheGeomPkg::*;
  import fetchBusPkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  // DUT default geometry mirrored for the model table
  localparam int L2CacheSize = 8;
  localparam int L2BlockSize = 6;
  localparam int NumLines    = 1 << (L2CacheSize - L2BlockSize);
  localparam int TagWidth    = AddrWidth - L2CacheSize;
  localparam int LineBytes   = 1 << L2BlockSize;
  localparam int WordsPerLine = LineBytes / 4;

  localparam int MissWindow    = 30;  // miss answers at request + 22
  localparam int NumRequests   = 330;
  localparam int TimeoutCycles = NumRequests * 30 + 100;  // plus reset slack for 10000
  localparam wordT WordKey     = 32'h5A17_C3E9;

  localparam addrT ColdBase   = 32'h0000_1000;
  localparam addrT ConflictA  = 32'h0000_2080;  // index 2
  localparam addrT ConflictB  = 32'h0000_3080;  // index 2 with another tag
  localparam addrT WindowBase = 32'h0000_4000;  // 2 KB random window

  typedef struct packed {
    wordT data;
    logic hit;
  } expRspT;

  logic     CLK_I;
  logic     RST_I;
  fetchReqT fetchReq;
  fetchRspT fetchRsp;
  logic     flush;
  memReqT   memReq;
  memBeatT  memBeat;
  int       memReqs;
  logic     memErr;

  // model table holding one tag and valid bit per index
  logic [TagWidth-1:0] modelTag [NumLines];
  logic [NumLines-1:0] modelValid;

  expRspT expRsp;        // owed response
  int     rspWindow;
  int     reqCycle;
  addrT   lastAddr;
  string  testName;
  int     sentCnt = 0;
  int     rspCnt = 0;
  int     expMemReqs = 0;
  int     cycleCnt = 0;

  clockGen u_clk (.CLK_I(CLK_I), .RST_I(RST_I));

  memModel #(.L2BlockSize(L2BlockSize)) u_mem (
    .CLK_I(CLK_I), .RST_I(RST_I), .memReq(memReq), .memBeat(memBeat),
    .reqCount(memReqs), .protoErr(memErr)
  );

  icacheTop u_dut (
    .CLK_I(CLK_I), .RST_I(RST_I), .fetchReq(fetchReq), .fetchRsp(fetchRsp),
    .flush(flush), .memReq(memReq), .memBeat(memBeat)
  );

  task automatic abortRun();
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic checkWord(string name, wordT expected, wordT actual);
    if (actual !== expected) begin
      $display("ERR %s: word expected %h, actual %h", name, expected, actual);
      abortRun();
    end
  endtask

  task automatic checkHit(string name, logic expected, logic actual);
    if (actual !== expected) begin
      $display("ERR %s: hit expected %b, actual %b", name, expected, actual);
      abortRun();
    end
  endtask

  // instruction memory word is the address xor key, rotated left by bits 6..2
  function automatic wordT memWordAt(addrT a);
    wordT        x;
    int unsigned sh;
    x  = a ^ WordKey;
    sh = 32'(a[6:2]);
    return (x << sh) | (x >> (32 - sh));
  endfunction

  // hit comes from the model table before the table takes the line
  function automatic expRspT predictFetch(addrT a);
    expRspT                          r;
    logic [L2CacheSize-L2BlockSize-1:0] idx;
    logic [TagWidth-1:0]             tg;
    idx        = a[L2CacheSize-1:L2BlockSize];
    tg         = a[AddrWidth-1:L2CacheSize];
    r.hit      = modelValid[idx] && (modelTag[idx] == tg);
    r.data     = memWordAt(a);
    modelValid[idx] = 1'b1;
    modelTag[idx]   = tg;
    return r;
  endfunction

  // send one request and wait until the compare process has seen its answer
  task automatic sendFetch(addrT a);
    @(posedge CLK_I);
    #1;
    expRsp    = predictFetch(a);
    expMemReqs = expRsp.hit ? expMemReqs : expMemReqs + 1;
    rspWindow = expRsp.hit ? 1 : MissWindow;
    reqCycle  = cycleCnt;
    lastAddr  = a;
    fetchReq  = '{valid: 1'b1, addr: a};
    sentCnt   = sentCnt + 1;
    @(posedge CLK_I);
    #1 fetchReq = '0;
    wait (rspCnt == sentCnt);
    if (memReqs != expMemReqs) begin
      $display("ERR %s: line requests expected %0d, actual %0d",
               testName, expMemReqs, memReqs);
      abortRun();
    end
  endtask

  task automatic flushCache();
    @(posedge CLK_I);
    #1;
    flush      = 1'b1;
    modelValid = '0;
    @(posedge CLK_I);
    #1 flush = 1'b0;
  endtask

  always @(posedge CLK_I) begin
    cycleCnt <= cycleCnt + 1;
    if (cycleCnt >= TimeoutCycles) begin
      $display("timeout: run went past %0d cycles", TimeoutCycles);
      abortRun();
    end
  end

  always @(posedge memErr) abortRun();  // protocol error flagged by the memory model

  // compare process samples responses mid cycle
  always @(negedge CLK_I) begin
    if (!RST_I) begin
      if (fetchRsp.valid) begin
        if (rspCnt == sentCnt) begin
          $display("%s: fetch response with data %h arrived with no request open",
                   testName, fetchRsp.data);
          abortRun();
        end else begin
          checkWord(testName, expRsp.data, fetchRsp.data);
          checkHit(testName, expRsp.hit, fetchRsp.hit);
          rspCnt = rspCnt + 1;
        end
      end else if (rspCnt != sentCnt && cycleCnt - reqCycle >= rspWindow) begin
        $display("%s: no response for address %h within %0d cycles",
                 testName, lastAddr, rspWindow);
        abortRun();
      end
    end
  end

  initial begin
    void'($urandom(23777));
    fetchReq   = '0;
    flush      = 1'b0;
    modelValid = '0;
    testName   = "reset";
    @(negedge RST_I);

    testName = "coldMiss";  // one line per index
    for (int i = 0; i < NumLines; i++) begin
      sendFetch(ColdBase + addrT'(i * LineBytes + i * 4));
    end

    testName = "repeatHit";  // every word of line 1 answered in one cycle
    for (int w = 0; w < WordsPerLine; w++) begin
      sendFetch(ColdBase + addrT'(LineBytes + w * 4));
    end

    testName = "conflict";
    for (int k = 0; k < 6; k++) begin
      sendFetch((k % 2 == 0) ? ConflictA : ConflictB);
    end

    testName = "flush";
    flushCache();
    for (int i = 0; i < NumLines; i++) begin
      sendFetch(ColdBase + addrT'(i * LineBytes));
    end

    testName = "random";
    for (int n = 0; n < 300; n++) begin
      sendFetch(WindowBase + addrT'($urandom_range(511, 0) * 4));
    end

    $display("Simulation passed");
    $finish;
  end

endmodule : icacheTb

/* tests/memModel.sv */
// instruction memory model: answers each line request with a burst of computed words
module memModel
  import cacheGeomPkg::*;
  import fetchBusPkg::*;
#(
  parameter int L2BlockSize = 6  // log2 of line bytes
) (
  input  logic    CLK_I,
  input  logic    RST_I,
  input  memReqT  memReq,
  output memBeatT memBeat,
  output int      reqCount,  // line requests seen so far
  output logic    protoErr   // set on a request the cache should never send
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int BeatsPerLine = 1 << (L2BlockSize - L2WordBytes);
  localparam int RespDelay    = 3;  // cycles from request to first beat
  localparam wordT WordKey    = 32'h5A17_C3E9;

  int   reqSeen = 0;
  int   doneCnt = 0;      // bursts finished
  logic errFlag = 1'b0;
  addrT lineAddr;         // address of the burst in flight

  assign reqCount = reqSeen;
  assign protoErr = errFlag;

  // memory contents: address xor key, rotated left by address bits 6..2
  function automatic wordT beatData(addrT a);
    wordT        x;
    int unsigned sh;
    x  = a ^ WordKey;
    sh = 32'(a[6:2]);
    return (x << sh) | (x >> (32 - sh));
  endfunction

  // request monitor, memReq is a flop output so the falling edge is safe
  always @(negedge CLK_I) begin
    if (!RST_I && memReq.valid) begin
      if (memReq.addr[L2BlockSize-1:0] != '0) begin
        $display("memory model: request at %h is not line aligned", memReq.addr);
        errFlag = 1'b1;
      end else if (reqSeen != doneCnt) begin
        $display("memory model: request at %h while a burst is still running", memReq.addr);
        errFlag = 1'b1;
      end
      lineAddr = memReq.addr;
      reqSeen  = reqSeen + 1;
    end
  end

  // burst driver, one beat per cycle in rising word order
  initial begin
    memBeat = '0;
    forever begin
      wait (reqSeen != doneCnt);
      repeat (RespDelay) @(posedge CLK_I);
      for (int b = 0; b < BeatsPerLine; b++) begin
        #1;
        memBeat = '{valid: 1'b1, data: beatData(lineAddr + addrT'(b * 4))};
        @(posedge CLK_I);
      end
      #1 memBeat = '0;
      doneCnt = doneCnt + 1;
    end
  end

endmodule : memModel

/* tests/clockGen.sv */
// testbench clock and reset source: 100 ns clock, reset held for the first 5 cycles
module clockGen (
  output logic CLK_I,
  output logic RST_I
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HalfPeriod = 50;  // ns
  localparam int ResetCycles = 5;

  initial begin
    CLK_I = 1'b0;
    forever #HalfPeriod CLK_I = ~CLK_I;
  end

  // release just after an edge, like every other input
  initial begin
    RST_I = 1'b1;
    repeat (ResetCycles) @(posedge CLK_I);
    #1 RST_I = 1'b0;
  end

endmodule : clockGen

/* verilog/icacheTop.sv */
// instruction cache top: array, refill engine and fetch controller wired together
module icacheTop
  import cacheGeomPkg::*;
  import fetchBusPkg::*;
#(
  parameter int L2CacheSize = 8,  // 256 byte cache
  parameter int L2BlockSize = 6   // 64 byte lines, 16 words
) (
  input  logic     CLK_I,
  input  logic     RST_I,
  input  fetchReqT fetchReq,
  output fetchRspT fetchRsp,
  input  logic     flush,
  output memReqT   memReq,
  input  memBeatT  memBeat
);

  localparam int LineWidth = 8 << L2BlockSize;

  // controller <-> array
  addrT                 lookupAddr;
  logic                 lookupHit;
  wordT                 lookupWord;
  logic                 fillStrobe;
  addrT                 fillAddr;
  logic [LineWidth-1:0] fillLine;

  // controller <-> refill engine
  logic                 refillStart;
  addrT                 refillAddr;
  logic                 lineDone;
  logic [LineWidth-1:0] line;

  icacheArray #(
    .L2CacheSize (L2CacheSize),
    .L2BlockSize (L2BlockSize)
  ) u_array (
    .CLK_I      (CLK_I),
    .RST_I      (RST_I),
    .lookupAddr (lookupAddr),
    .lookupHit  (lookupHit),
    .lookupWord (lookupWord),
    .fillStrobe (fillStrobe),
    .fillAddr   (fillAddr),
    .fillLine   (fillLine),
    .flush      (flush)
  );

  refillEngine #(
    .L2BlockSize (L2BlockSize)
  ) u_refill (
    .CLK_I       (CLK_I),
    .RST_I       (RST_I),
    .refillStart (refillStart),
    .refillAddr  (refillAddr),
    .memReq      (memReq),
    .memBeat     (memBeat),
    .lineDone    (lineDone),
    .line        (line)
  );

  fetchControl #(
    .L2BlockSize (L2BlockSize)
  ) u_ctrl (
    .CLK_I       (CLK_I),
    .RST_I       (RST_I),
    .fetchReq    (fetchReq),
    .fetchRsp    (fetchRsp),
    .lookupAddr  (lookupAddr),
    .lookupHit   (lookupHit),
    .lookupWord  (lookupWord),
    .refillStart (refillStart),
    .refillAddr  (refillAddr),
    .lineDone    (lineDone),
    .line        (line),
    .fillStrobe  (fillStrobe),
    .fillAddr    (fillAddr),
    .fillLine    (fillLine)
  );

endmodule : icacheTop

/* verilog/fetchControl.sv */
// fetch controller FSM: takes fetch requests, answers hits, runs refills and replays misses
module fetchControl
  import cacheGeomPkg::*;
  import fetchBusPkg::*;
#(
  parameter int L2BlockSize = 6  // log2 of line bytes
) (
  input  logic                        CLK_I,
  input  logic                        RST_I,
  // fetcher side
  input  fetchReqT                    fetchReq,
  output fetchRspT                    fetchRsp,
  // array lookup
  output addrT                        lookupAddr,
  input  logic                        lookupHit,
  input  wordT                        lookupWord,
  // refill engine
  output logic                        refillStart,
  output addrT                        refillAddr,
  input  logic                        lineDone,
  input  logic [(8<<L2BlockSize)-1:0] line,
  // array fill
  output logic                        fillStrobe,
  output addrT                        fillAddr,
  output logic [(8<<L2BlockSize)-1:0] fillLine
);

  typedef enum logic [1:0] {
    stIdle,    // nothing outstanding
    stLookup,  // array answers for the held address
    stRefill,  // waiting on the refill engine
    stReplay   // line written, read it back
  } ctlStateT;

  ctlStateT state;
  ctlStateT nextState;
  addrT     reqAddr;    // held request address
  logic     rspValid;   // response strobe this cycle
  logic     rspHit;
  logic     acceptReq;  // new request taken at this edge

  // responses come straight off the array in lookup and replay
  assign rspValid = ((state == stLookup) && lookupHit) || (state == stReplay);
  assign rspHit   = (state == stLookup);  // replay always reports a miss
  assign fetchRsp = '{valid: rspValid, data: lookupWord, hit: rspHit};

  // next request may land in the same cycle as the current response
  assign acceptReq = fetchReq.valid && ((state == stIdle) || rspValid);

  assign lookupAddr  = reqAddr;
  assign refillAddr  = reqAddr;
  assign refillStart = (state == stLookup) && !lookupHit;

  // fill with whatever the engine hands back, tag comes from the held address
  assign fillStrobe = (state == stRefill) && lineDone;
  assign fillAddr   = reqAddr;
  assign fillLine   = line;

  always_comb begin
    nextState = state;
    case (state)
      stIdle: begin
        if (acceptReq) nextState = stLookup;
      end
      stLookup: begin
        if (!lookupHit) begin
          nextState = stRefill;  // miss, engine starts this cycle
        end else if (acceptReq) begin
          nextState = stLookup;  // back to back hit path
        end else begin
          nextState = stIdle;
        end
      end
      stRefill: begin
        if (lineDone) nextState = stReplay;
      end
      stReplay: begin
        nextState = acceptReq ? stLookup : stIdle;
      end
      default: nextState = stIdle;
    endcase
  end

  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      state <= stIdle;
    end else begin
      state <= nextState;
    end
  end

  // request address, held until the response goes out
  always_ff @(posedge CLK_I) begin
    if (acceptReq) begin
      reqAddr <= fetchReq.addr;
    end
  end

endmodule : fetchControl

/* verilog/refillEngine.sv */
// refill engine: requests one line from instruction memory and assembles its beats
module refillEngine
  import cacheGeomPkg::*;
  import fetchBusPkg::*;
#(
  parameter int L2BlockSize = 6  // log2 of line bytes
) (
  input  logic                        CLK_I,
  input  logic                        RST_I,
  // start strobe from the fetch controller
  input  logic                        refillStart,
  input  addrT                        refillAddr,
  // memory side
  output memReqT                      memReq,
  input  memBeatT                     memBeat,
  // finished line back to the fetch controller
  output logic                        lineDone,
  output logic [(8<<L2BlockSize)-1:0] line
);

  localparam int BeatCntWidth = L2BlockSize - L2WordBytes;
  localparam int BeatsPerLine = 1 << BeatCntWidth;
  localparam int LineWidth    = 8 << L2BlockSize;

  logic                    reqValid;  // memReq strobe, one cycle after start
  logic                    busy;      // burst in flight
  logic [BeatCntWidth-1:0] beatCnt;   // beats taken so far
  logic                    lastBeat;
  addrT                    lineAddr;  // aligned line address
  logic [LineWidth-1:0]    lineReg;   // shift register for the line

  assign lastBeat = memBeat.valid && (beatCnt == BeatCntWidth'(BeatsPerLine - 1));

  assign memReq = '{valid: reqValid, addr: lineAddr};
  assign line   = lineReg;

  // control: request strobe, busy flag, beat count, done strobe
  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      reqValid <= 1'b0;
      busy     <= 1'b0;
      beatCnt  <= '0;
      lineDone <= 1'b0;
    end else begin
      reqValid <= refillStart;  // issue next cycle, exactly once
      lineDone <= busy && lastBeat;
      if (refillStart) begin
        busy    <= 1'b1;
        beatCnt <= '0;
      end else if (busy && memBeat.valid) begin
        beatCnt <= beatCnt + 1'b1;
        if (lastBeat) begin
          busy <= 1'b0;  // back to idle with the line complete
        end
      end
    end
  end

  // payload: latch aligned address, shift beats in from the top
  always_ff @(posedge CLK_I) begin
    if (refillStart) begin
      lineAddr <= {refillAddr[AddrWidth-1:L2BlockSize], {L2BlockSize{1'b0}}};
    end
    if (busy && memBeat.valid) begin
      // first beat ends up in the low word after the last shift
      lineReg <= {memBeat.data, lineReg[LineWidth-1:WordWidth]};
    end
  end

endmodule : refillEngine

/* verilog/icacheArray.sv */
// direct-mapped tag, valid and line storage with combinational lookup, line fill and flush
module icacheArray
  import cacheGeomPkg::*;
#(
  parameter int L2CacheSize = 8,  // log2 of cache bytes
  parameter int L2BlockSize = 6   // log2 of line bytes
) (
  input  logic                          CLK_I,
  input  logic                          RST_I,
  // lookup side, answered in the same cycle
  input  addrT                          lookupAddr,
  output logic                          lookupHit,
  output wordT                          lookupWord,
  // fill side, written at the clock edge
  input  logic                          fillStrobe,
  input  addrT                          fillAddr,
  input  logic [(8<<L2BlockSize)-1:0]   fillLine,
  // drop every line
  input  logic                          flush
);

  // derived geometry
  localparam int IndexWidth  = L2CacheSize - L2BlockSize;
  localparam int TagWidth    = AddrWidth - L2CacheSize;
  localparam int OffsetWidth = L2BlockSize - L2WordBytes;  // word select bits
  localparam int LineWidth   = 8 << L2BlockSize;
  localparam int Depth       = 1 << IndexWidth;

  logic [LineWidth-1:0] lineMem [Depth];  // line payload
  logic [TagWidth-1:0]  tagMem  [Depth];  // stored tags
  logic [Depth-1:0]     validBits;        // one per line

  // lookup address fields
  logic [TagWidth-1:0]    lkTag;
  logic [IndexWidth-1:0]  lkIndex;
  logic [OffsetWidth-1:0] lkOffset;
  logic [LineWidth-1:0]   lkLine;

  // fill address fields, offset bits are ignored here
  logic [TagWidth-1:0]    fillTag;
  logic [IndexWidth-1:0]  fillIndex;

  assign lkTag    = lookupAddr[AddrWidth-1:L2CacheSize];
  assign lkIndex  = lookupAddr[L2CacheSize-1:L2BlockSize];
  assign lkOffset = lookupAddr[L2BlockSize-1:L2WordBytes];

  assign fillTag   = fillAddr[AddrWidth-1:L2CacheSize];
  assign fillIndex = fillAddr[L2CacheSize-1:L2BlockSize];

  // read the indexed line, then pick the word
  assign lkLine     = lineMem[lkIndex];
  assign lookupWord = lkLine[lkOffset*WordWidth +: WordWidth];  // word 0 sits in the low bits

  // valid bit guards the tag compare, stale tags never match
  assign lookupHit = validBits[lkIndex] && (tagMem[lkIndex] == lkTag);

  // valid bits: flush wins, otherwise a fill marks its slot
  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      validBits <= '0;
    end else if (flush) begin
      validBits <= '0;  // whole cache invalid next cycle
    end else if (fillStrobe) begin
      validBits[fillIndex] <= 1'b1;
    end
  end

  // payload and tag write, one line per fill
  always_ff @(posedge CLK_I) begin
    if (fillStrobe) begin
      lineMem[fillIndex] <= fillLine;
      tagMem[fillIndex]  <= fillTag;
    end
  end

endmodule : icacheArray

/* verilog/fetchBusPkg.sv */
// fetch bus package: request and response structs for the fetcher and memory sides
package fetchBusPkg;

  import cacheGeomPkg::*;

  // fetcher -> cache, one-cycle strobe
  typedef struct packed {
    logic valid;  // request strobe
    addrT addr;   // byte address of the wanted word
  } fetchReqT;

  // cache -> fetcher, one-cycle strobe
  typedef struct packed {
    logic valid;  // response strobe
    wordT data;   // instruction word
    logic hit;    // set when served from the array without a refill
  } fetchRspT;

  // cache -> memory, one strobe per line refill
  typedef struct packed {
    logic valid;  // request strobe
    addrT addr;   // line aligned byte address
  } memReqT;

  // memory -> cache, one strobe per word
  // beats arrive in rising word order, gaps allowed
  typedef struct packed {
    logic valid;  // beat strobe
    wordT data;   // one word of the line
  } memBeatT;

endpackage : fetchBusPkg

/* verilog/cacheGeomPkg.sv */
// cache geometry package: fixed address and word widths plus their base types
package cacheGeomPkg;

  // byte address width seen by the fetcher and by instruction memory
  localparam int AddrWidth = 32;

  // one instruction word
  localparam int WordWidth = 32;

  // log2 of bytes per word, so word offsets start at this bit
  localparam int L2WordBytes = 2;

  // byte address, word aligned in practice but carried whole
  typedef logic [AddrWidth-1:0] addrT;

  // instruction word as returned to the fetcher
  typedef logic [WordWidth-1:0] wordT;

  // cache size and line size are module parameters of the top level,
  // everything that depends on them is derived inside each block

endpackage : cacheGeomPkg
